//--- design/i2cPkg.sv
// I2C master block shared definitions
// Bus command codes, CSR map, field widths and bit-engine operations
`default_nettype none

package i2cPkg;

	// ----------------------------------------
	// Bus address layout
	// ----------------------------------------
	localparam int busAdrsBits = 32;

	// Command field in address bits 31:30
	localparam logic [1:0] cmdNone  = 2'd0;
	localparam logic [1:0] cmdWrite = 2'd1;
	localparam logic [1:0] cmdRead  = 2'd2;
	localparam logic [1:0] cmdWrRd  = 2'd3;	// Combined access, not supported

	localparam logic [7:0] blockAdrs = 8'h01;	// Block field in bits 23:16

	// ----------------------------------------
	// CSR map
	// ----------------------------------------
	localparam logic [15:0] csrCtrl   = 16'h0000;
	localparam logic [15:0] csrDiv    = 16'h0004;
	localparam logic [15:0] csrXfer   = 16'h0008;
	localparam logic [15:0] csrStatus = 16'h000C;

	localparam int divBits = 16;
	localparam logic [divBits-1:0] divReset = 16'd4;	// Quarter period = div+1 clocks

	// Device 23:17, register 15:8, data 7:0
	localparam int xferBits = 24;

	// Bit engine operations
	localparam logic [1:0] opStart = 2'd0;
	localparam logic [1:0] opStop  = 2'd1;
	localparam logic [1:0] opWrite = 2'd2;
	localparam logic [1:0] opRead  = 2'd3;

endpackage

`default_nettype wire

//--- design/i2cBitCtrl.sv
// I2C bit engine
// Splits each operation into four SCL quarter periods of div+1 clocks
// and drives the open-drain enables for start, stop, write and read
`timescale 1ns/1ps
`default_nettype none

module i2cBitCtrl
	import i2cPkg::*;
(
	input  wire                sysClk,
	input  wire                rstN,
	input  wire [divBits-1:0]  div,
	input  wire                opValid,
	input  wire [1:0]          op,
	input  wire                txBit,
	output logic               opDone,
	output logic               rxBit,
	output logic               sclOe,	// 1 pulls SCL low
	output logic               sdaOe,	// 1 pulls SDA low
	input  wire                sdaIn
);

logic               active;
logic [1:0]         phase;	// Quarter index
logic [divBits-1:0] quarterCnt;
logic [1:0]         opReg;
logic               txReg;
logic               quarterEnd;

assign quarterEnd = active && (quarterCnt == div);

// ----------------------------------------
// Quarter period sequencer
// ----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		active     <= 1'b0;
		phase      <= 2'd0;
		quarterCnt <= '0;
		opReg      <= opStart;
		txReg      <= 1'b0;
		opDone     <= 1'b0;
	end
	else
	begin
		opDone <= 1'b0;
		if (!active)
		begin
			if (opValid)
			begin
				active     <= 1'b1;
				phase      <= 2'd0;
				quarterCnt <= '0;
				opReg      <= op;
				txReg      <= txBit;
			end
		end
		else if (quarterEnd)
		begin
			quarterCnt <= '0;
			phase      <= phase + 2'd1;
			if (phase == 2'd3)
			begin
				active <= 1'b0;
				opDone <= 1'b1;	// Last quarter over
			end
		end
		else
			quarterCnt <= quarterCnt + 1'b1;
	end
end

// ----------------------------------------
// Line drive per op and quarter
// ----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		sclOe <= 1'b0;	// Lines released
		sdaOe <= 1'b0;
		rxBit <= 1'b0;
	end
	else if (active)
	begin
		case (opReg)
			opStart:
			begin
				case (phase)
					2'd0:    sdaOe <= 1'b0;	// Release SDA, SCL as it was
					2'd1:    sclOe <= 1'b0;
					2'd2:    sdaOe <= 1'b1;	// SDA falls with SCL high
					default: sclOe <= 1'b1;
				endcase
			end
			opStop:
			begin
				case (phase)
					2'd0:    sdaOe <= 1'b1;	// SDA low while SCL low
					2'd1:    sclOe <= 1'b0;
					2'd2:    sdaOe <= 1'b0;	// SDA rises with SCL high
					default: ;
				endcase
			end
			opWrite:
			begin
				case (phase)
					2'd0:    sdaOe <= ~txReg;
					2'd1:    sclOe <= 1'b0;
					2'd3:    sclOe <= 1'b1;
					default: ;	// Data held while SCL high
				endcase
			end
			default:
			begin
				case (phase)
					2'd0: sdaOe <= 1'b0;	// Let the target drive
					2'd1: sclOe <= 1'b0;
					2'd2:
						if (quarterEnd)
							rxBit <= sdaIn;	// Late in the high quarter
					default: sclOe <= 1'b1;
				endcase
			end
		endcase
	end
end

endmodule

`default_nettype wire

//--- design/i2cUnit.sv
// I2C transfer sequencer
// Runs one register write or register read transaction as a chain of
// bit-engine operations, checks ACKs and collects the read byte
`timescale 1ns/1ps
`default_nettype none

module i2cUnit
	import i2cPkg::*;
(
	input  wire                  sysClk,
	input  wire                  rstN,
	input  wire                  enable,
	input  wire [divBits-1:0]    div,
	input  wire [xferBits-1:0]   xfer,
	input  wire                  go,
	input  wire                  readMode,
	output logic                 busy,
	output logic                 done,
	output logic                 nack,
	output logic [7:0]           rdByte,
	// Open-drain lines
	output logic                 sclOe,
	input  wire                  sclIn,
	output logic                 sdaOe,
	input  wire                  sdaIn
);

typedef enum logic [3:0] {
	sIdle,
	sBusWait,	// Wait for both lines released
	sStart,
	sTxBit,
	sTxAck,
	sReStart,
	sRxBit,
	sRxNack,
	sStop
} unitState_t;

unitState_t            state;
logic [xferBits-1:0]   xferReg;	// Sampled at go
logic                  rdMode;
logic [7:0]            shiftReg;
logic [2:0]            bitCnt;
logic [1:0]            byteIdx;	// 0 dev wr, 1 reg, 2 data, 3 dev rd
logic                  waiting;	// Op issued, opDone pending
logic                  opValid;
logic [1:0]            op;
logic                  txBit;
logic                  opDone;
logic                  rxBit;

assign busy = (state != sIdle);

// Operation for the current phase
always_comb
begin
	op    = opWrite;
	txBit = shiftReg[7];	// MSB first
	case (state)
		sStart, sReStart: op = opStart;
		sStop:            op = opStop;
		sTxAck, sRxBit:   op = opRead;
		sRxNack:          txBit = 1'b1;	// Master NACK ends the read
		default: ;
	endcase
end

// ----------------------------------------
// Transaction FSM
// ----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		state    <= sIdle;
		xferReg  <= '0;
		rdMode   <= 1'b0;
		shiftReg <= 8'd0;
		bitCnt   <= 3'd0;
		byteIdx  <= 2'd0;
		waiting  <= 1'b0;
		opValid  <= 1'b0;
		done     <= 1'b0;
		nack     <= 1'b0;
		rdByte   <= 8'd0;
	end
	else
	begin
		opValid <= 1'b0;
		done    <= 1'b0;
		case (state)
			sIdle:
			begin
				if (go && enable)
				begin
					xferReg <= xfer;
					rdMode  <= readMode;
					nack    <= 1'b0;
					rdByte  <= 8'd0;
					byteIdx <= 2'd0;
					state   <= sBusWait;
				end
			end
			sBusWait:
				if (sclIn && sdaIn)
					state <= sStart;
			default:
			begin
				if (!waiting)
				begin
					opValid <= 1'b1;	// One op in flight
					waiting <= 1'b1;
				end
				else if (opDone)
				begin
					waiting <= 1'b0;
					case (state)
						sStart:
						begin
							shiftReg <= {xferReg[23:17], 1'b0};	// Write bit
							bitCnt   <= 3'd0;
							state    <= sTxBit;
						end
						sTxBit:
						begin
							shiftReg <= {shiftReg[6:0], 1'b0};
							bitCnt   <= bitCnt + 3'd1;
							if (bitCnt == 3'd7)
								state <= sTxAck;
						end
						sTxAck:
						begin
							if (rxBit)
							begin
								nack  <= 1'b1;	// Target did not ACK
								state <= sStop;
							end
							else
							begin
								case (byteIdx)
									2'd0:
									begin
										shiftReg <= xferReg[15:8];
										byteIdx  <= 2'd1;
										state    <= sTxBit;
									end
									2'd1:
									begin
										if (rdMode)
											state <= sReStart;
										else
										begin
											shiftReg <= xferReg[7:0];
											byteIdx  <= 2'd2;
											state    <= sTxBit;
										end
									end
									2'd2: state <= sStop;
									default: state <= sRxBit;	// bitCnt wrapped to 0
								endcase
							end
						end
						sReStart:
						begin
							shiftReg <= {xferReg[23:17], 1'b1};	// Read bit
							byteIdx  <= 2'd3;
							state    <= sTxBit;
						end
						sRxBit:
						begin
							shiftReg <= {shiftReg[6:0], rxBit};
							bitCnt   <= bitCnt + 3'd1;
							if (bitCnt == 3'd7)
							begin
								rdByte <= {shiftReg[6:0], rxBit};
								state  <= sRxNack;
							end
						end
						sRxNack: state <= sStop;
						default:
						begin
							done  <= 1'b1;	// Stop finished
							state <= sIdle;
						end
					endcase
				end
			end
		endcase
	end
end

// Bit engine
i2cBitCtrl bitCtrl_i (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.div     (div),
	.opValid (opValid),
	.op      (op),
	.txBit   (txBit),
	.opDone  (opDone),
	.rxBit   (rxBit),
	.sclOe   (sclOe),
	.sdaOe   (sdaOe),
	.sdaIn   (sdaIn)
);

endmodule

`default_nettype wire

//--- design/i2cCsr.sv
// I2C control and status registers
// Decodes bus accesses for this block, holds enable, divider and
// transfer word, and returns registered read data
`timescale 1ns/1ps
`default_nettype none

module i2cCsr
	import i2cPkg::*;
(
	input  wire                    sysClk,
	input  wire                    rstN,
	// Bus slave side
	input  wire [31:0]             wrData,
	input  wire [busAdrsBits-1:0]  adrs,
	input  wire                    cke,
	output logic [31:0]            rdData,
	output logic                   rdValid,
	// Toward the transfer unit
	output logic                   enable,
	output logic [divBits-1:0]     div,
	output logic [xferBits-1:0]    xfer,
	output logic                   go,
	output logic                   readMode,
	input  wire                    busy,
	input  wire                    done,
	input  wire                    nack,
	input  wire [7:0]              rdByte
);

logic [1:0]  cmd;
logic [7:0]  blkField;
logic [15:0] csrAdrs;
logic        wrHit;
logic        rdHit;
logic        nackReg;	// Captured at done
logic [7:0]  lastByte;	// Last byte read from the target

assign cmd      = adrs[busAdrsBits-1 -: 2];
assign blkField = adrs[23:16];
assign csrAdrs  = adrs[15:0];

// ----------------------------------------
// Access decode
// ----------------------------------------
always_comb
begin
	wrHit = 1'b0;
	rdHit = 1'b0;
	if (cke && (blkField == blockAdrs))
	begin
		case (cmd)
			cmdWrite: wrHit = 1'b1;
			cmdRead:  rdHit = 1'b1;
			cmdNone, cmdWrRd: ;	// No effect
		endcase
	end
end

// ----------------------------------------
// Register file
// ----------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		enable   <= 1'b0;
		div      <= divReset;
		xfer     <= '0;
		go       <= 1'b0;
		readMode <= 1'b0;
		nackReg  <= 1'b0;
		lastByte <= 8'd0;
		rdValid  <= 1'b0;
	end
	else
	begin
		go      <= 1'b0;	// Single cycle strobe
		rdValid <= rdHit;
		if (wrHit)
		begin
			case (csrAdrs)
				csrCtrl:
				begin
					enable   <= wrData[0];
					go       <= wrData[1];
					readMode <= wrData[2];	// Held alongside go
				end
				csrDiv:  div  <= wrData[divBits-1:0];
				csrXfer: xfer <= wrData[xferBits-1:0];
				default: ;	// Status is read only
			endcase
		end
		if (done)
		begin
			nackReg  <= nack;
			lastByte <= rdByte;
		end
	end
end

// Read mux, data valid one cycle after cke
always_ff @(posedge sysClk)
begin
	if (rdHit)
	begin
		case (csrAdrs)
			csrCtrl:   rdData <= {29'd0, readMode, 1'b0, enable};
			csrDiv:    rdData <= {{(32-divBits){1'b0}}, div};
			csrXfer:   rdData <= {{(32-xferBits){1'b0}}, xfer};
			csrStatus:
				rdData <= {16'd0, (done ? rdByte : lastByte), 6'd0,
					(done ? nack : nackReg), busy};	// Fresh result in the done cycle
			default:   rdData <= 32'd0;
		endcase
	end
end

endmodule

`default_nettype wire

//--- design/i2cBlock.sv
// I2C master block top
// Bus slave CSR in front of the transaction sequencer, lines leave
// as open-drain pull-low enables
`timescale 1ns/1ps
`default_nettype none

module i2cBlock
	import i2cPkg::*;
(
	input  wire                    sysClk,
	input  wire                    rstN,
	// Bus slave
	input  wire [31:0]             wrData,
	input  wire [busAdrsBits-1:0]  adrs,
	input  wire                    cke,
	output logic [31:0]            rdData,
	output logic                   rdValid,
	// I2C lines
	output logic                   sclOe,
	input  wire                    sclIn,
	output logic                   sdaOe,
	input  wire                    sdaIn
);

// ----------------------------------------
// CSR to unit
// ----------------------------------------
logic                enable;
logic [divBits-1:0]  div;
logic [xferBits-1:0] xfer;
logic                go;
logic                readMode;
logic                busy;
logic                done;
logic                nack;
logic [7:0]          rdByte;

i2cCsr csr_i (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.wrData   (wrData),
	.adrs     (adrs),
	.cke      (cke),
	.rdData   (rdData),
	.rdValid  (rdValid),
	.enable   (enable),
	.div      (div),
	.xfer     (xfer),
	.go       (go),
	.readMode (readMode),
	.busy     (busy),
	.done     (done),
	.nack     (nack),
	.rdByte   (rdByte)
);

i2cUnit unit_i (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.enable   (enable),
	.div      (div),
	.xfer     (xfer),
	.go       (go),
	.readMode (readMode),
	.busy     (busy),
	.done     (done),
	.nack     (nack),
	.rdByte   (rdByte),
	.sclOe    (sclOe),
	.sclIn    (sclIn),
	.sdaOe    (sdaOe),
	.sdaIn    (sdaIn)
);

endmodule

`default_nettype wire

//--- bench/i2cSlaveModel.sv
// Behavioral I2C target for the testbench
// Acks one device address, holds a 256-byte register array,
// supports register write and register read with repeated start
`timescale 1ns/1ps
`default_nettype none

module i2cSlaveModel (
	input  wire       scl,
	input  wire       sda,
	input  wire [6:0] devAdrs,
	output logic      sdaOe	// 1 pulls SDA low
);

typedef enum logic [1:0] {stIdle, stAddr, stReg, stData} slvState_t;

logic [7:0] mem [0:255];
slvState_t  state;
logic       readSel;	// Address byte carried the read bit
logic       sending;
logic [3:0] bitCnt;	// 8 is the ACK slot
logic [7:0] shiftIn;
logic [7:0] txByte;
logic [7:0] regPtr;
logic       lastScl;
logic       lastSda;

initial
begin
	for (int i = 0; i < 256; i++)
		mem[i] = (i[7:0] * 8'd7) ^ 8'h3C;	// Pattern over all address bits
	state   = stIdle;
	readSel = 1'b0;
	sending = 1'b0;
	bitCnt  = 4'd0;
	shiftIn = 8'd0;
	txByte  = 8'd0;
	regPtr  = 8'd0;
	sdaOe   = 1'b0;
	lastScl = 1'b1;
	lastSda = 1'b1;
end

// Byte received, decide the ACK
task automatic ackByte();
	case (state)
		stAddr:
			if (shiftIn[7:1] == devAdrs)
			begin
				sdaOe   = 1'b1;
				readSel = shiftIn[0];
				state   = stReg;
			end
			else
				state = stIdle;	// Not ours, stay off the bus
		stReg:
		begin
			if (!readSel)
				regPtr = shiftIn;
			sdaOe = 1'b1;
			state = stData;
		end
		default:
		begin
			mem[regPtr] = shiftIn;
			sdaOe       = 1'b1;
		end
	endcase
endtask

// End of the ACK slot
task automatic endAck();
	if (readSel && (state == stReg) && !sending)
	begin
		sending = 1'b1;	// Read address acked, return data
		txByte  = mem[regPtr];
		sdaOe   = ~txByte[7];
	end
	else if (sending)
	begin
		sending = 1'b0;	// Master NACK or ACK, read is over
		state   = stIdle;
	end
endtask

// ----------------------------------------
// Line watcher
// ----------------------------------------
always @(scl or sda)
begin
	if (scl && lastScl && lastSda && !sda)
	begin
		state   = stAddr;	// Start or repeated start
		bitCnt  = 4'd8;	// SCL fall after start closes like an ACK slot
		sending = 1'b0;
		readSel = 1'b0;
		sdaOe   = 1'b0;
	end
	else if (scl && lastScl && !lastSda && sda)
	begin
		state   = stIdle;	// Stop
		sending = 1'b0;
		sdaOe   = 1'b0;
	end
	else if (scl && !lastScl && (state != stIdle))
	begin
		if ((bitCnt < 4'd8) && !sending)
			shiftIn = {shiftIn[6:0], sda};
	end
	else if (!scl && lastScl && (state != stIdle))
	begin
		if (bitCnt < 4'd7)
		begin
			bitCnt = bitCnt + 4'd1;
			if (sending)
				sdaOe = ~txByte[7 - bitCnt];
		end
		else if (bitCnt == 4'd7)
		begin
			bitCnt = 4'd8;
			if (sending)
				sdaOe = 1'b0;	// Master drives ACK slot
			else
				ackByte();
		end
		else
		begin
			bitCnt = 4'd0;
			sdaOe  = 1'b0;
			endAck();
		end
	end
	lastScl = scl;
	lastSda = sda;
end

endmodule

`default_nettype wire

//--- bench/i2cBlock_asserts.sv
// Protocol checks on the I2C bit engine
// SDA stability while SCL is high, opDone width and idle lines after reset
`timescale 1ns/1ps
`default_nettype none

module i2cBlock_asserts
	import i2cPkg::*;
(
	input wire       sysClk,
	input wire       rstN,
	input wire       sclOe,
	input wire       sdaOe,
	input wire       opDone,
	input wire [1:0] opReg
);

// SDA moves only with SCL low, start and stop excepted
sdaStable: assert property (@(posedge sysClk) disable iff (!rstN)
	(!sclOe && !$past(sclOe) && (opReg != opStart) && (opReg != opStop))
	|-> $stable(sdaOe))
	else $error("SDA changed while SCL was high");

opDonePulse: assert property (@(posedge sysClk) disable iff (!rstN)
	opDone |=> !opDone)
	else $error("opDone longer than one cycle");

// Released lines in reset
linesIdle: assert property (@(posedge sysClk)
	!rstN |-> (!sclOe && !sdaOe))
	else $error("Line enables active during reset");

endmodule

`default_nettype wire

//--- bench/i2cBlockTb.sv
// Testbench for the I2C master block
// Bus tasks, a target model on wired-AND lines and the scenario run
`timescale 1ns/1ps
`default_nettype none

module i2cBlockTb
	import i2cPkg::*;
();

logic                   sysClk;
logic                   rstN;
logic [31:0]            wrData;
logic [busAdrsBits-1:0] adrs;
logic                   cke;
logic [31:0]            rdData;
logic                   rdValid;
logic                   sclOe;
logic                   sdaOe;
logic                   slvSdaOe;
wire                    scl;
wire                    sda;
integer                 seed;
logic [31:0]            rd;
logic [7:0]             regA;
logic [7:0]             dataA;
logic [7:0]             keep;

assign scl = ~sclOe;	// Pull-up, low when driven
assign sda = ~sdaOe & ~slvSdaOe;

i2cBlock i2cBlock_i (
	.sysClk (sysClk), .rstN (rstN), .wrData (wrData), .adrs (adrs), .cke (cke),
	.rdData (rdData), .rdValid (rdValid), .sclOe (sclOe), .sclIn (scl),
	.sdaOe (sdaOe), .sdaIn (sda)
);

i2cSlaveModel slave_i (.scl (scl), .sda (sda), .devAdrs (7'h50), .sdaOe (slvSdaOe));

bind i2cBitCtrl i2cBlock_asserts asserts_i (
	.sysClk (sysClk), .rstN (rstN), .sclOe (sclOe), .sdaOe (sdaOe),
	.opDone (opDone), .opReg (opReg)
);

initial
begin
	sysClk = 1'b0;
	forever #50 sysClk = ~sysClk;
end

task automatic failRun(input string msg);
	$display("%s", msg);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic checkEqual(input string testName, input logic [31:0] expected,
	input logic [31:0] actual);
	assert (actual === expected)
	else failRun($sformatf("Mismatch %s expected %0h actual %0h", testName, expected, actual));
endtask

function automatic logic [31:0] makeAdrs(input logic [1:0] cmd, input logic [7:0] blk,
	input logic [15:0] offset);
	return {cmd, 6'd0, blk, offset};
endfunction

// ----------------------------------------
// Bus access tasks
// ----------------------------------------
task automatic busWrite(input logic [1:0] cmd, input logic [7:0] blk,
	input logic [15:0] offset, input logic [31:0] data);
	@(negedge sysClk);
	adrs   = makeAdrs(cmd, blk, offset);
	wrData = data;
	cke    = 1'b1;
	@(negedge sysClk);
	cke  = 1'b0;
	adrs = '0;
endtask

task automatic busRead(input logic [7:0] blk, input logic [15:0] offset,
	input logic expectValid, output logic [31:0] data);
	@(negedge sysClk);
	adrs = makeAdrs(cmdRead, blk, offset);
	cke  = 1'b1;
	@(negedge sysClk);
	cke  = 1'b0;
	adrs = '0;
	checkEqual("rdValid after cke", {31'd0, expectValid}, {31'd0, rdValid});
	data = rdData;
	@(negedge sysClk);
	checkEqual("rdValid one cycle", 32'd0, {31'd0, rdValid});
endtask

// Poll status until busy drops
task automatic waitIdle(output logic [31:0] status);
	int polls;
	polls  = 0;
	status = 32'd1;
	while (status[0])
	begin
		busRead(blockAdrs, csrStatus, 1'b1, status);
		polls++;
		if (polls > 5000)
			failRun("Transfer still busy after the timeout");
	end
endtask

task automatic runXfer(input logic [6:0] dev, input logic [7:0] regNum,
	input logic [7:0] data, input logic readMode, output logic [31:0] status);
	busWrite(cmdWrite, blockAdrs, csrXfer, {8'd0, dev, 1'b0, regNum, data});
	busWrite(cmdWrite, blockAdrs, csrCtrl, {29'd0, readMode, 2'b11});
	waitIdle(status);
endtask

// ----------------------------------------
// Scenario sequence
// ----------------------------------------
initial
begin
	rstN   = 1'b0;
	wrData = '0;
	adrs   = '0;
	cke    = 1'b0;
	seed   = 96240;
	repeat (3) @(negedge sysClk);
	rstN = 1'b1;

	busRead(blockAdrs, csrCtrl, 1'b1, rd);
	checkEqual("reset ctrl", 32'd0, rd);
	busRead(blockAdrs, csrDiv, 1'b1, rd);
	checkEqual("reset div", {16'd0, divReset}, rd);
	busRead(blockAdrs, csrStatus, 1'b1, rd);
	checkEqual("reset status", 32'd0, rd);

	regA  = $random(seed);
	dataA = $random(seed);
	runXfer(7'h50, regA, dataA, 1'b0, rd);
	checkEqual("write nack", 32'd0, {31'd0, rd[1]});
	checkEqual("write model data", {24'd0, dataA}, {24'd0, slave_i.mem[regA]});

	runXfer(7'h50, regA, 8'h00, 1'b1, rd);
	checkEqual("read nack", 32'd0, {31'd0, rd[1]});
	checkEqual("read byte", {24'd0, dataA}, {24'd0, rd[15:8]});

	keep = slave_i.mem[regA ^ 8'h01];
	runXfer(7'h51, regA ^ 8'h01, ~keep, 1'b0, rd);
	checkEqual("wrong device nack", 32'd1, {31'd0, rd[1]});
	checkEqual("wrong device lines", 32'd3, {30'd0, scl, sda});	// Stop done
	checkEqual("wrong device model", {24'd0, keep}, {24'd0, slave_i.mem[regA ^ 8'h01]});

	// Accesses that must be ignored
	busWrite(cmdWrite, 8'h02, csrDiv, 32'd9);
	busWrite(cmdWrRd, blockAdrs, csrDiv, 32'd9);
	busRead(blockAdrs, csrDiv, 1'b1, rd);
	checkEqual("ignored div", {16'd0, divReset}, rd);
	busRead(8'h02, csrDiv, 1'b0, rd);
	busWrite(cmdWrite, blockAdrs, csrCtrl, 32'd2);	// go without enable
	repeat (4)
	begin
		busRead(blockAdrs, csrStatus, 1'b1, rd);
		checkEqual("go disabled busy", 32'd0, {31'd0, rd[0]});
	end

	busWrite(cmdWrite, blockAdrs, csrDiv, 32'd1);
	regA  = $random(seed);
	dataA = $random(seed);
	runXfer(7'h50, regA, dataA, 1'b0, rd);
	checkEqual("div1 nack", 32'd0, {31'd0, rd[1]});
	checkEqual("div1 model data", {24'd0, dataA}, {24'd0, slave_i.mem[regA]});

	$display("TEST OK");
	$finish;
end

endmodule

`default_nettype wire

//--- i2cBlock.f
design/i2cPkg.sv
design/i2cBitCtrl.sv
design/i2cUnit.sv
design/i2cCsr.sv
design/i2cBlock.sv
bench/i2cSlaveModel.sv
bench/i2cBlock_asserts.sv
bench/i2cBlockTb.sv

//--- run.sh
#!/bin/bash
# Build and run the I2C block simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module i2cBlockTb -o i2cBlockSim -f i2cBlock.f

# Run output goes to the log, the status is taken from it below
./obj_dir/i2cBlockSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
